// File: Makefile
VERILATOR  = verilator
TOP        = video_daisy_tb
FILELIST   = all.f
OBJ_DIR    = obj_dir
BIN        = $(OBJ_DIR)/V$(TOP)
FLAGS      = --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
+incdir+include
verilog/video_pkg.sv
verilog/video_axil_regs.sv
verilog/video_frame_counter.sv
verilog/video_bar_gen.sv
verilog/video_sprite_gen.sv
verilog/video_compositor.sv
verilog/video_daisy_top.sv
sim/video_daisy_properties.sv
sim/video_daisy_tb.sv

// File: include/video_regs.svh
// --------------------------------------------------------------------------
// Video pipeline register map
// AXI4-Lite offsets, field positions and response codes
// --------------------------------------------------------------------------

`ifndef VIDEO_REGS_SVH
`define VIDEO_REGS_SVH

`define REG_CTRL    12'h000  // bit 0 sprite enable, bit 1 gray enable
`define REG_BAR     12'h004  // Bar shift in bits 2:0
`define REG_POS     12'h008  // Sprite x in 9:0, y in 25:16
`define REG_KEY     12'h00C  // Transparent colour, 12 bits
`define REG_SPRITE  12'h100  // Sprite RAM window, one word per pixel

`define POS_Y_LSB   16

`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10

`endif

// File: sim/video_daisy_properties.sv
// --------------------------------------------------------------------------
// Handshake properties
// Valid holds with its payload until ready and is low after reset;
// bound to the pixel stream and both AXI4-Lite response channels
// --------------------------------------------------------------------------

module video_daisy_properties #(
    parameter int W = 1
) (
    input logic         sys_clk,
    input logic         rst,
    input logic         vld,
    input logic         rdy,
    input logic [W-1:0] data
);
    timeunit 1ns;
    timeprecision 100ps;

    // Transfer only on ready
    a_vld_hold: assert property (@(posedge sys_clk) disable iff (rst) vld && !rdy |=> vld)
        else $error("valid dropped while ready was low");

    a_data_hold: assert property (@(posedge sys_clk) disable iff (rst)
                                  vld && !rdy |=> $stable(data))
        else $error("payload changed while stalled");

    a_rst_idle: assert property (@(posedge sys_clk) rst |=> !vld)
        else $error("valid high after reset");

endmodule

bind video_compositor video_daisy_properties #(.W(33)) u_pix_props (
    .sys_clk(sys_clk), .rst(rst), .vld(pix_vld), .rdy(pix_rdy), .data(pix)
);

bind video_axil_regs video_daisy_properties #(.W(2)) u_b_props (
    .sys_clk(sys_clk), .rst(rst), .vld(bvalid), .rdy(bready), .data(bresp)
);

bind video_axil_regs video_daisy_properties #(.W(34)) u_r_props (
    .sys_clk(sys_clk), .rst(rst), .vld(rvalid), .rdy(rready), .data({rdata, rresp})
);

// File: sim/video_daisy_tb.sv
// --------------------------------------------------------------------------
// Video pixel pipeline testbench
// Plays register and frame commands from a file, models the bars,
// sprite overlay and gray rule, checks every pixel of a frame
// --------------------------------------------------------------------------

`include "video_regs.svh"

module video_daisy_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import video_pkg::*;

    localparam int H_ACTIVE    = 32;
    localparam int V_ACTIVE    = 16;
    localparam int SPRITE_SIZE = 8;
    localparam int SPR_WORDS   = SPRITE_SIZE * SPRITE_SIZE;
    localparam int TIMEOUT     = 200;   // Cycles per wait

    // White, yellow, cyan, green, magenta, red, blue, black
    localparam rgb_t BAR_COLOURS [8] = '{12'hFFF, 12'hFF0, 12'h0FF, 12'h0F0,
                                        12'hF0F, 12'hF00, 12'h00F, 12'h000};

    logic        sys_clk, rst;
    logic [11:0] awaddr, araddr;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic [31:0] wdata, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;
    video_pix_t  pix;
    logic        pix_vld, pix_rdy;
    integer      seed;

    // Register and sprite model
    logic        m_sprite_en, m_gray_en;
    int          m_bar_shift, m_sx, m_sy;
    rgb_t        m_key;
    rgb_t        sprite_model [SPR_WORDS];

    video_daisy_top #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .SPRITE_SIZE(SPRITE_SIZE))
        u_video_daisy_top (.*);

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;   // 50 MHz
    end

    // ------------------------------------------------------------------------
    // Failure reporting and compares
    // ------------------------------------------------------------------------
    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t, %s", $time, what);
        stop_run();
    endtask

    task automatic check_rgb(input rgb_t exp, input rgb_t act, input string name);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_pos(input video_pos_t exp, input video_pos_t act, input string name);
        if (act !== exp) begin
            $display("ERR %0t %s expected hc=%0d vc=%0d fs=%0b actual hc=%0d vc=%0d fs=%0b",
                     $time, name, exp.hc, exp.vc, exp.frame_start,
                     act.hc, act.vc, act.frame_start);
            stop_run();
        end
    endtask

    task automatic check_resp(input logic [1:0] exp, input logic [1:0] act, input string name);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_data(input logic [31:0] exp, input logic [31:0] act, input string name);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    // ------------------------------------------------------------------------
    // Pixel model
    // ------------------------------------------------------------------------
    function automatic rgb_t expect_rgb(input int hc, input int vc);
        rgb_t  mix, spr;
        int    gsum;
        chan_t g;
        mix = BAR_COLOURS[3'(hc >> m_bar_shift)];   // Bar number modulo 8
        if (m_sprite_en && hc >= m_sx && hc < m_sx + SPRITE_SIZE
                && vc >= m_sy && vc < m_sy + SPRITE_SIZE) begin
            spr = sprite_model[6'((vc - m_sy) * SPRITE_SIZE + hc - m_sx)];
            if (spr != m_key)
                mix = spr;                              // Key colour shows the bar
        end
        if (!m_gray_en)
            return mix;
        gsum = int'(mix[11:8]) + 2 * int'(mix[7:4]) + int'(mix[3:0]);
        g    = chan_t'(gsum / 4);
        return {g, g, g};
    endfunction

    task automatic update_model(input logic [11:0] addr, input logic [31:0] data);
        case (addr)
            `REG_CTRL: begin
                m_sprite_en = data[0];
                m_gray_en   = data[1];
            end
            `REG_BAR:  m_bar_shift = int'(data[2:0]);
            `REG_POS: begin
                m_sx = int'(data[9:0]);
                m_sy = int'(data[25:16]);
            end
            `REG_KEY:  m_key = data[11:0];
            default:   sprite_model[6'((addr - `REG_SPRITE) >> 2)] = data[11:0];
        endcase
    endtask

    // ------------------------------------------------------------------------
    // AXI4-Lite driver, inputs change 2 ns after the edge
    // ------------------------------------------------------------------------
    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        int n;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        do begin
            @(negedge sys_clk);                 // Sampled mid cycle
            n++;
            if (n > TIMEOUT) report_timeout("awready and wready never rose");
        end while (!(awready && wready));
        @(posedge sys_clk);                     // AW and W taken here
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        n = 0;
        do begin
            @(negedge sys_clk);
            n++;
            if (n > TIMEOUT) report_timeout("bvalid never rose");
        end while (!bvalid);
        resp = bresp;
        @(posedge sys_clk);                     // Response taken
        #2;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        do begin
            @(negedge sys_clk);
            n++;
            if (n > TIMEOUT) report_timeout("arready never rose");
        end while (!arready);
        @(posedge sys_clk);                     // Address taken here
        #2;
        arvalid = 1'b0;
        rready  = 1'b1;
        n = 0;
        do begin
            @(negedge sys_clk);
            n++;
            if (n > TIMEOUT) report_timeout("rvalid never rose");
        end while (!rvalid);
        data = rdata;
        resp = rresp;
        @(posedge sys_clk);
        #2;
        rready = 1'b0;
    endtask

    // Every fourth word gets the key colour so transparency shows up
    task automatic seed_sprite();
        int          i;
        logic [31:0] rnd;
        logic [1:0]  resp;
        rgb_t        c;
        for (i = 0; i < SPR_WORDS; i++) begin
            rnd = $random(seed);
            c   = (i % 4 == 0) ? m_key : rnd[11:0];
            axi_write(12'(`REG_SPRITE + 4 * i), {20'd0, c}, 4'hF, resp);
            check_resp(`RESP_OKAY, resp, "bresp");
            update_model(12'(`REG_SPRITE + 4 * i), {20'd0, c});
        end
    endtask

    // ------------------------------------------------------------------------
    // Pixel stream
    // ------------------------------------------------------------------------
    task automatic take_pixel(output video_pix_t p);
        int          n;
        logic        got;
        logic [31:0] rnd;
        n   = 0;
        got = 1'b0;
        while (!got) begin
            @(negedge sys_clk);                 // Transfer due on the next edge
            if (pix_vld && pix_rdy) begin
                p   = pix;
                got = 1'b1;
            end
            @(posedge sys_clk);
            #2;
            rnd     = $random(seed);
            pix_rdy = (rnd[1:0] != 2'b00);      // Ready three cycles in four
            n++;
            if (n > TIMEOUT) report_timeout("no pixel accepted on the stream");
        end
    endtask

    task automatic check_frame();
        video_pix_t p;
        video_pos_t exp_pos;
        int         hc, vc, n;
        take_pixel(p);                          // Output register, old settings
        take_pixel(p);                          // Generator stage, old settings
        n = 0;
        do begin
            take_pixel(p);
            n++;
            if (n > H_ACTIVE * V_ACTIVE) report_timeout("no frame_start within one frame");
        end while (!p.pos.frame_start);
        for (vc = 0; vc < V_ACTIVE; vc++) begin
            for (hc = 0; hc < H_ACTIVE; hc++) begin
                if (hc != 0 || vc != 0)
                    take_pixel(p);
                exp_pos.hc          = hcount_t'(hc);
                exp_pos.vc          = vcount_t'(vc);
                exp_pos.frame_start = (hc == 0) && (vc == 0);
                check_pos(exp_pos, p.pos, "pix.pos");
                check_rgb(expect_rgb(hc, vc), p.rgb, "pix.rgb");
            end
        end
        pix_rdy = 1'b0;                         // Stall between commands
    endtask

    // pix_vld due on the second edge after reset
    task automatic check_valid_rise();
        int n;
        n = 0;
        do begin
            @(posedge sys_clk);
            #1;
            n++;
            if (n > TIMEOUT) report_timeout("pix_vld never rose after reset");
        end while (!pix_vld);
        if (n != 2) begin
            $display("ERR %0t pix_vld rise cycle expected 2 actual %0d", $time, n);
            stop_run();
        end
        #1;
    endtask

    // ------------------------------------------------------------------------
    // Command file player
    // ------------------------------------------------------------------------
    task automatic play_commands();
        int              fd, got;
        logic [7:0]      cmd;
        logic [11:0]     addr;
        logic [31:0]     data, act_data;
        logic [3:0]      strb;
        logic [1:0]      exp_resp, act_resp;
        logic [8*96-1:0] rest;
        fd = $fopen("sim/video_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the command file sim/video_input.txt");
            stop_run();
        end
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd == "#") begin
                got = $fgets(rest, fd);         // Skip comment text
            end else if (cmd == "W") begin
                got = $fscanf(fd, "%h %h %h %h", addr, data, strb, exp_resp);
                if (got != 4) begin
                    $display("Malformed W line in the command file");
                    stop_run();
                end
                axi_write(addr, data, strb, act_resp);
                check_resp(exp_resp, act_resp, "bresp");
                if (exp_resp == `RESP_OKAY)
                    update_model(addr, data);
            end else if (cmd == "R") begin
                got = $fscanf(fd, "%h %h %h", addr, data, exp_resp);
                if (got != 3) begin
                    $display("Malformed R line in the command file");
                    stop_run();
                end
                axi_read(addr, act_data, act_resp);
                check_data(data, act_data, "rdata");
                check_resp(exp_resp, act_resp, "rresp");
            end else if (cmd == "S") begin
                seed_sprite();
            end else if (cmd == "F") begin
                check_frame();
            end else begin
                $display("Unknown command %s in the command file", cmd);
                stop_run();
            end
        end
        $fclose(fd);
    endtask

    initial begin
        seed        = 32'h104dc883;
        rst         = 1'b1;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        pix_rdy     = 1'b0;
        m_sprite_en = 1'b0;
        m_gray_en   = 1'b0;
        m_bar_shift = 2;                        // Reset bar width 4
        m_sx        = 0;
        m_sy        = 0;
        m_key       = '0;
        repeat (3) @(posedge sys_clk);
        #2;
        rst = 1'b0;
        check_valid_rise();
        play_commands();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: sim/video_input.txt
# W addr data strb resp writes and checks bresp; R addr data resp reads and checks
# S writes random sprite words, F checks one full frame; all numbers hex
R 000 00000000 0
R 004 00000002 0
W 000 00000003 f 0
R 000 00000003 0
W 004 00000005 f 0
R 004 00000005 0
W 008 0007001c f 0
R 008 0007001c 0
W 00c 00000abc f 0
R 00c 00000abc 0
W 010 12345678 f 2
R 010 00000000 2
W 004 00000001 3 2
R 004 00000005 0
W 200 00000123 f 2
R 104 00000000 0
# Bars only, two bar widths
W 000 00000000 f 0
W 004 00000002 f 0
F
W 004 00000000 f 0
F
# Sprite window partly off the right edge, then gray
W 008 0005001c f 0
S
W 000 00000001 f 0
F
W 000 00000003 f 0
F

// File: verilog/video_axil_regs.sv
// --------------------------------------------------------------------------
// AXI4-Lite register slave
// Holds the pipeline control registers and forwards writes
// to the sprite RAM window as single cycle pulses
// --------------------------------------------------------------------------

`include "video_regs.svh"

module video_axil_regs #(
    parameter int SPRITE_SIZE = 16
) (
    input  logic                    sys_clk,
    input  logic                    rst,
    input  logic [11:0]             awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic [3:0]              wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [11:0]             araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [31:0]             rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    output video_pkg::video_ctrl_t  ctrl,
    output video_pkg::sprite_wr_t   spr_wr
);
    import video_pkg::*;

    localparam video_ctrl_t CTRL_RESET = '{bar_shift: 3'd2, default: '0};

    axil_state_t wr_state, rd_state;
    logic        wr_go, wr_ok, rd_go;
    logic [31:0] rd_mux;

    // Word index inside the sprite window
    function automatic logic [9:0] word_idx(input logic [11:0] a);
        return a[11:2] - 10'h040;
    endfunction

    function automatic logic addr_ok(input logic [11:0] a);
        if (a >= `REG_SPRITE)
            return int'(word_idx(a)) < SPRITE_SIZE * SPRITE_SIZE;
        return a == `REG_CTRL || a == `REG_BAR || a == `REG_POS || a == `REG_KEY;
    endfunction

    // ------------------------------------------------------------------------
    // Write channel
    // ------------------------------------------------------------------------
    assign wr_go   = (wr_state == IDLE) && awvalid && wvalid;
    assign awready = wr_go;                       // AW and W taken together
    assign wready  = wr_go;
    assign bvalid  = (wr_state == RESP);
    assign wr_ok   = addr_ok(awaddr) && (wstrb == 4'hF);

    assign spr_wr.en   = wr_go && wr_ok && (awaddr >= `REG_SPRITE);
    assign spr_wr.addr = spr_addr_t'(word_idx(awaddr));
    assign spr_wr.rgb  = wdata[11:0];

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            wr_state <= IDLE;
            bresp    <= `RESP_OKAY;
            ctrl     <= CTRL_RESET;
        end else if (wr_go) begin
            wr_state <= RESP;
            bresp    <= wr_ok ? `RESP_OKAY : `RESP_SLVERR;
            if (wr_ok) begin
                case (awaddr)
                    `REG_CTRL: {ctrl.gray_en, ctrl.sprite_en} <= wdata[1:0];
                    `REG_BAR:  ctrl.bar_shift <= wdata[2:0];
                    `REG_POS: begin
                        ctrl.sprite_x <= wdata[H_W-1:0];
                        ctrl.sprite_y <= wdata[`POS_Y_LSB +: V_W];
                    end
                    `REG_KEY:  ctrl.key <= wdata[11:0];
                    default: ;                    // Sprite words go to the RAM
                endcase
            end
        end else if (bready) begin
            wr_state <= IDLE;                     // Response taken
        end
    end

    // ------------------------------------------------------------------------
    // Read channel
    // ------------------------------------------------------------------------
    assign arready = (rd_state == IDLE);
    assign rvalid  = (rd_state == RESP);
    assign rd_go   = arready && arvalid;

    always_comb begin
        case (araddr)
            `REG_CTRL: rd_mux = {30'd0, ctrl.gray_en, ctrl.sprite_en};
            `REG_BAR:  rd_mux = {29'd0, ctrl.bar_shift};
            `REG_POS:  rd_mux = {6'd0, ctrl.sprite_y, 6'd0, ctrl.sprite_x};
            `REG_KEY:  rd_mux = {20'd0, ctrl.key};
            default:   rd_mux = '0;               // Sprite RAM is write only
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            rd_state <= IDLE;
            rdata    <= '0;
            rresp    <= `RESP_OKAY;
        end else if (rd_go) begin
            rd_state <= RESP;
            rdata    <= rd_mux;
            rresp    <= addr_ok(araddr) ? `RESP_OKAY : `RESP_SLVERR;
        end else if (rready) begin
            rd_state <= IDLE;
        end
    end

endmodule

// File: verilog/video_bar_gen.sv
// --------------------------------------------------------------------------
// Colour bar generator
// Picks a palette colour from the column and registers it
// together with the coordinate
// --------------------------------------------------------------------------

module video_bar_gen (
    input  logic                    sys_clk,
    input  logic                    rst,
    input  logic                    advance,
    input  video_pkg::video_pos_t   pos,
    input  video_pkg::video_ctrl_t  ctrl,
    output video_pkg::rgb_t         bar_rgb,
    output video_pkg::video_pos_t   bar_pos
);
    import video_pkg::*;

    logic [2:0] bar_idx;

    // Bar number wraps every eight bars
    assign bar_idx = 3'(pos.hc >> ctrl.bar_shift);

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            bar_pos <= '0;            // No frame_start out of reset
        end else if (advance) begin
            bar_pos <= pos;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (advance)
            bar_rgb <= BAR_PALETTE[bar_idx];
    end

endmodule

// File: verilog/video_compositor.sv
// --------------------------------------------------------------------------
// Compositor
// Overlays the sprite on the bars, optional gray conversion,
// output register on a valid/ready stream and pipeline advance
// --------------------------------------------------------------------------

module video_compositor (
    input  logic                    sys_clk,
    input  logic                    rst,
    input  video_pkg::rgb_t         bar_rgb,
    input  video_pkg::video_pos_t   bar_pos,
    input  video_pkg::rgb_t         spr_rgb,
    input  logic                    spr_hit,
    input  video_pkg::video_ctrl_t  ctrl,
    output video_pkg::video_pix_t   pix,
    output logic                    pix_vld,
    input  logic                    pix_rdy,
    output logic                    advance
);
    import video_pkg::*;

    logic       gen_full;     // Generator stage holds a pixel
    rgb_t       mix, out_rgb;
    logic [5:0] gray_sum;
    chan_t      gray;

    // ------------------------------------------------------------------------
    // Colour path
    // ------------------------------------------------------------------------
    assign mix = spr_hit ? spr_rgb : bar_rgb;

    // (R + 2G + B) / 4
    assign gray_sum = {2'b00, mix[11:8]} + {1'b0, mix[7:4], 1'b0} + {2'b00, mix[3:0]};
    assign gray     = gray_sum[5:2];
    assign out_rgb  = ctrl.gray_en ? {gray, gray, gray} : mix;

    // ------------------------------------------------------------------------
    // Output stage and advance
    // ------------------------------------------------------------------------
    assign advance = !pix_vld || pix_rdy;  // Empty or being taken

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            gen_full <= 1'b0;
            pix_vld  <= 1'b0;
        end else if (advance) begin
            gen_full <= 1'b1;                   // Full from the first advance on
            pix_vld  <= gen_full;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (advance) begin
            pix.pos <= bar_pos;
            pix.rgb <= out_rgb;
        end
    end

endmodule

// File: verilog/video_daisy_top.sv
// --------------------------------------------------------------------------
// Video pixel pipeline top
// AXI4-Lite control, frame counter, bar and sprite generators
// in parallel, joined by the compositor onto the pixel stream
// --------------------------------------------------------------------------

module video_daisy_top #(
    parameter int H_ACTIVE    = 640,
    parameter int V_ACTIVE    = 480,
    parameter int SPRITE_SIZE = 16
) (
    input  logic                   sys_clk,
    input  logic                   rst,
    input  logic [11:0]            awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [31:0]            wdata,
    input  logic [3:0]             wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [11:0]            araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [31:0]            rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,
    output video_pkg::video_pix_t  pix,
    output logic                   pix_vld,
    input  logic                   pix_rdy
);
    import video_pkg::*;

    video_ctrl_t ctrl;
    sprite_wr_t  spr_wr;
    video_pos_t  pos, bar_pos;
    rgb_t        bar_rgb, spr_rgb;
    logic        spr_hit;
    logic        advance;

    // ------------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------------
    video_axil_regs #(.SPRITE_SIZE(SPRITE_SIZE)) u_video_axil_regs (
        .sys_clk(sys_clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .ctrl(ctrl), .spr_wr(spr_wr)
    );

    // ------------------------------------------------------------------------
    // Pixel path
    // ------------------------------------------------------------------------
    video_frame_counter #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_video_frame_counter (
        .sys_clk(sys_clk), .rst(rst), .advance(advance), .pos(pos)
    );

    video_bar_gen u_video_bar_gen (
        .sys_clk(sys_clk), .rst(rst), .advance(advance), .pos(pos), .ctrl(ctrl),
        .bar_rgb(bar_rgb), .bar_pos(bar_pos)
    );

    video_sprite_gen #(.SPRITE_SIZE(SPRITE_SIZE)) u_video_sprite_gen (
        .sys_clk(sys_clk), .rst(rst), .advance(advance), .pos(pos), .ctrl(ctrl),
        .spr_wr(spr_wr), .spr_rgb(spr_rgb), .spr_hit(spr_hit)
    );

    video_compositor u_video_compositor (
        .sys_clk(sys_clk), .rst(rst),
        .bar_rgb(bar_rgb), .bar_pos(bar_pos),
        .spr_rgb(spr_rgb), .spr_hit(spr_hit), .ctrl(ctrl),
        .pix(pix), .pix_vld(pix_vld), .pix_rdy(pix_rdy), .advance(advance)
    );

endmodule

// File: verilog/video_frame_counter.sv
// --------------------------------------------------------------------------
// Frame counter
// Walks the active picture left to right, top to bottom,
// one coordinate per pipeline advance
// --------------------------------------------------------------------------

module video_frame_counter #(
    parameter int H_ACTIVE = 640,
    parameter int V_ACTIVE = 480
) (
    input  logic                   sys_clk,
    input  logic                   rst,
    input  logic                   advance,
    output video_pkg::video_pos_t  pos
);
    import video_pkg::*;

    hcount_t hc;
    vcount_t vc;
    logic    last_col, last_row;

    assign last_col = (hc == hcount_t'(H_ACTIVE - 1));
    assign last_row = (vc == vcount_t'(V_ACTIVE - 1));

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            hc <= '0;
            vc <= '0;
        end else if (advance) begin
            if (last_col) begin
                hc <= '0;                                // Next line
                vc <= last_row ? '0 : vc + 1'b1;         // Or next frame
            end else begin
                hc <= hc + 1'b1;
            end
        end
    end

    // Coordinate on offer to both generators
    assign pos.hc          = hc;
    assign pos.vc          = vc;
    assign pos.frame_start = (hc == '0) && (vc == '0);

endmodule

// File: verilog/video_pkg.sv
// --------------------------------------------------------------------------
// Video pipeline package
// Raster widths, colour types, control structs and the bar palette
// --------------------------------------------------------------------------

package video_pkg;

    localparam int H_W       = 10;
    localparam int V_W       = 10;
    localparam int SPRITE_AW = 8;   // Up to 16x16 sprite

    typedef logic [H_W-1:0]       hcount_t;
    typedef logic [V_W-1:0]       vcount_t;
    typedef logic [3:0]           chan_t;
    typedef logic [11:0]          rgb_t;      // R 11:8, G 7:4, B 3:0
    typedef logic [SPRITE_AW-1:0] spr_addr_t;

    typedef struct packed {
        hcount_t hc;
        vcount_t vc;
        logic    frame_start;   // Set at (0,0)
    } video_pos_t;

    typedef struct packed {
        video_pos_t pos;
        rgb_t       rgb;
    } video_pix_t;

    typedef struct packed {
        logic       sprite_en;
        logic       gray_en;
        logic [2:0] bar_shift;  // Bar width 2**bar_shift
        hcount_t    sprite_x;
        vcount_t    sprite_y;
        rgb_t       key;        // Transparent sprite colour
    } video_ctrl_t;

    typedef struct packed {
        logic      en;
        spr_addr_t addr;
        rgb_t      rgb;
    } sprite_wr_t;

    // White, yellow, cyan, green, magenta, red, blue, black
    localparam rgb_t BAR_PALETTE [8] = '{
        12'hFFF, 12'hFF0, 12'h0FF, 12'h0F0,
        12'hF0F, 12'hF00, 12'h00F, 12'h000
    };

    typedef enum logic {IDLE, RESP} axil_state_t;

endpackage

// File: verilog/video_sprite_gen.sv
// --------------------------------------------------------------------------
// Sprite generator
// Sprite RAM with a write port from the register block and a
// synchronous read at the window offset of each coordinate
// --------------------------------------------------------------------------

module video_sprite_gen #(
    parameter int SPRITE_SIZE = 16
) (
    input  logic                    sys_clk,
    input  logic                    rst,
    input  logic                    advance,
    input  video_pkg::video_pos_t   pos,
    input  video_pkg::video_ctrl_t  ctrl,
    input  video_pkg::sprite_wr_t   spr_wr,
    output video_pkg::rgb_t         spr_rgb,
    output logic                    spr_hit
);
    import video_pkg::*;

    rgb_t      mem [2**SPRITE_AW];
    hcount_t   dx;
    vcount_t   dy;
    logic      in_win, in_win_q;
    spr_addr_t rd_addr;

    // ------------------------------------------------------------------------
    // Window test
    // ------------------------------------------------------------------------
    assign dx = pos.hc - ctrl.sprite_x;
    assign dy = pos.vc - ctrl.sprite_y;

    assign in_win = ctrl.sprite_en
                 && (pos.hc >= ctrl.sprite_x) && (dx < hcount_t'(SPRITE_SIZE))
                 && (pos.vc >= ctrl.sprite_y) && (dy < vcount_t'(SPRITE_SIZE));

    // Row major offset inside the sprite
    assign rd_addr = spr_addr_t'(int'(dy) * SPRITE_SIZE + int'(dx));

    always_ff @(posedge sys_clk) begin
        if (rst)
            in_win_q <= 1'b0;
        else if (advance)
            in_win_q <= in_win;
    end

    // ------------------------------------------------------------------------
    // Sprite RAM
    // ------------------------------------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (spr_wr.en)
            mem[spr_wr.addr] <= spr_wr.rgb;
        if (advance)
            spr_rgb <= mem[rd_addr];  // Read moves with the pipeline
    end

    // Key test needs the read data, so after the register
    assign spr_hit = in_win_q && (spr_rgb != ctrl.key);

endmodule
